/* ack_tracker.sv */
// wishbone acknowledge tracker
// counts strobes issued but not yet acknowledged and keeps
// a sticky error flag for the burst in progress
module ack_tracker (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	input  logic i_start,
	input  logic i_issued,
	input  logic i_wb_ack,
	input  logic i_wb_err,
	output logic o_idle,
	output logic o_err
);
	import axi2wb_pkg::*;

	ack_cnt_t cnt_q;
	ack_cnt_t cnt_nxt;
	logic     err_q;

	// count after this cycle's issue and ack
	always_comb
	begin
		cnt_nxt = cnt_q;
		// error abandons everything still in flight
		if (i_wb_err)
			cnt_nxt = '0;
		else if (i_issued && !i_wb_ack)
			cnt_nxt = cnt_q + ack_cnt_t'(1);
		// stray ack with nothing pending is ignored
		else if (!i_issued && i_wb_ack && (cnt_q != '0))
			cnt_nxt = cnt_q - ack_cnt_t'(1);
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			cnt_q <= '0;
			err_q <= 1'b0;
		end
		else
		begin
			cnt_q <= cnt_nxt;
			// sticky until the next burst starts
			if (i_wb_err)
				err_q <= 1'b1;
			else if (i_start)
				err_q <= 1'b0;
		end
	end

	// idle once the last ack has been seen this cycle
	assign o_idle = (cnt_nxt == '0);

	// error reported in the cycle it arrives, then held
	assign o_err = err_q || i_wb_err;

endmodule

/* axi2wb_pkg.sv */
// axi2wb write bridge shared definitions
// bus widths, vector types, burst and FSM encodings, B response codes
package axi2wb_pkg;

	////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////
	localparam int AXI_ADDR_W = 28;
	localparam int AXI_DATA_W = 32;
	localparam int AXI_ID_W   = 6;
	// byte offset inside one data word
	localparam int AXI_LSBS   = 2;
	// wishbone addresses whole words
	localparam int WB_ADDR_W  = AXI_ADDR_W - AXI_LSBS;
	// enough for 256 outstanding strobes
	localparam int ACK_CNT_W  = 9;

	////////////////////////////////////////////////////////////
	// vector types
	////////////////////////////////////////////////////////////
	typedef logic [AXI_ADDR_W-1:0]   axi_addr_t;
	typedef logic [WB_ADDR_W-1:0]    wb_addr_t;
	typedef logic [AXI_DATA_W-1:0]   data_t;
	typedef logic [AXI_DATA_W/8-1:0] strb_t;
	typedef logic [AXI_ID_W-1:0]     axi_id_t;
	// AWLEN, beats minus one
	typedef logic [7:0]              beat_len_t;
	typedef logic [2:0]              axi_size_t;
	typedef logic [ACK_CNT_W-1:0]    ack_cnt_t;

	// AWBURST encoding
	typedef enum logic [1:0] {
		BURST_FIXED = 2'b00,
		BURST_INCR  = 2'b01,
		BURST_WRAP  = 2'b10
	} burst_t;

	// write burst FSM
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BURST,
		ST_DRAIN,
		ST_RESP
	} wr_state_t;

	// BRESP codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* axi2wb_write.f */
axi2wb_pkg.sv
wb_beat_if.sv
burst_addr_gen.sv
wb_write_issue.sv
ack_tracker.sv
write_ctrl.sv
axi2wb_write.sv
tb_clk_gen.sv
tb_axi2wb_write.sv

/* axi2wb_write.sv */
// AXI4 write channels to pipelined wishbone write master
// one burst in flight, one wishbone strobe per W beat,
// single B response with OKAY or SLVERR per burst
module axi2wb_write (
	input  logic                  S_AXI_ACLK,
	input  logic                  S_AXI_ARESETN,
	// write address channel
	input  logic                  S_AXI_AWVALID,
	output logic                  S_AXI_AWREADY,
	input  axi2wb_pkg::axi_id_t   S_AXI_AWID,
	input  axi2wb_pkg::axi_addr_t S_AXI_AWADDR,
	input  axi2wb_pkg::beat_len_t S_AXI_AWLEN,
	input  axi2wb_pkg::axi_size_t S_AXI_AWSIZE,
	input  logic [1:0]            S_AXI_AWBURST,
	// write data channel
	input  logic                  S_AXI_WVALID,
	output logic                  S_AXI_WREADY,
	input  axi2wb_pkg::data_t     S_AXI_WDATA,
	input  axi2wb_pkg::strb_t     S_AXI_WSTRB,
	// burst end comes from AWLEN, WLAST is not looked at
	input  logic                  S_AXI_WLAST,
	// write response channel
	output logic                  S_AXI_BVALID,
	input  logic                  S_AXI_BREADY,
	output axi2wb_pkg::axi_id_t   S_AXI_BID,
	output logic [1:0]            S_AXI_BRESP,
	// wishbone master, shares clock and reset
	output logic                  o_wb_cyc,
	output logic                  o_wb_stb,
	output axi2wb_pkg::wb_addr_t  o_wb_addr,
	output axi2wb_pkg::data_t     o_wb_data,
	output axi2wb_pkg::strb_t     o_wb_sel,
	input  logic                  i_wb_stall,
	input  logic                  i_wb_ack,
	input  logic                  i_wb_err
);
	import axi2wb_pkg::*;

	wb_beat_if beat_if ();

	wb_addr_t cur_addr;
	logic     addr_load;
	logic     addr_step;
	logic     burst_start;
	logic     wb_issued;
	logic     ack_idle;
	logic     ack_err;

	////////////////////////////////////////////////////////////
	// burst control
	////////////////////////////////////////////////////////////
	write_ctrl u_write_ctrl (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_awvalid     (S_AXI_AWVALID),
		.i_awid        (S_AXI_AWID),
		.i_awlen       (S_AXI_AWLEN),
		.i_wvalid      (S_AXI_WVALID),
		.i_wdata       (S_AXI_WDATA),
		.i_wstrb       (S_AXI_WSTRB),
		.i_bready      (S_AXI_BREADY),
		.i_cur_addr    (cur_addr),
		.i_idle        (ack_idle),
		.i_err         (ack_err),
		.o_awready     (S_AXI_AWREADY),
		.o_wready      (S_AXI_WREADY),
		.o_wb_cyc      (o_wb_cyc),
		.o_bvalid      (S_AXI_BVALID),
		.o_bid         (S_AXI_BID),
		.o_bresp       (S_AXI_BRESP),
		.o_load        (addr_load),
		.o_step        (addr_step),
		.o_start       (burst_start),
		.beat          (beat_if.ctrl)
	);

	burst_addr_gen u_burst_addr_gen (
		.S_AXI_ACLK (S_AXI_ACLK),
		.i_load     (addr_load),
		.i_step     (addr_step),
		.i_addr     (S_AXI_AWADDR),
		.i_size     (S_AXI_AWSIZE),
		.i_burst    (burst_t'(S_AXI_AWBURST)),
		.o_wb_addr  (cur_addr)
	);

	////////////////////////////////////////////////////////////
	// wishbone side
	////////////////////////////////////////////////////////////
	wb_write_issue u_wb_write_issue (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_abort       (ack_err),
		.i_wb_stall    (i_wb_stall),
		.beat          (beat_if.issue),
		.o_wb_stb      (o_wb_stb),
		.o_wb_addr     (o_wb_addr),
		.o_wb_data     (o_wb_data),
		.o_wb_sel      (o_wb_sel),
		.o_issued      (wb_issued)
	);

	ack_tracker u_ack_tracker (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_start       (burst_start),
		.i_issued      (wb_issued),
		.i_wb_ack      (i_wb_ack),
		.i_wb_err      (i_wb_err),
		.o_idle        (ack_idle),
		.o_err         (ack_err)
	);

endmodule

/* burst_addr_gen.sv */
// AXI burst address generator
// holds start address, size and burst type of the active burst
// and moves the address on by one transfer size after each beat
module burst_addr_gen (
	input  logic                  S_AXI_ACLK,
	input  logic                  i_load,
	input  logic                  i_step,
	input  axi2wb_pkg::axi_addr_t i_addr,
	input  axi2wb_pkg::axi_size_t i_size,
	input  axi2wb_pkg::burst_t    i_burst,
	output axi2wb_pkg::wb_addr_t  o_wb_addr
);
	import axi2wb_pkg::*;

	axi_addr_t addr_q;
	axi_size_t size_q;
	burst_t    burst_q;

	// low address bits covered by one transfer
	axi_addr_t size_mask;
	axi_addr_t next_addr;

	// align down, then add 2^size
	// mask + 1 is the transfer size in bytes
	always_comb
	begin
		size_mask = (axi_addr_t'(1) << size_q) - axi_addr_t'(1);
		next_addr = (addr_q & ~size_mask) + size_mask + axi_addr_t'(1);
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_load)
		begin
			addr_q  <= i_addr;
			// bus is one word wide, larger sizes act as a word
			size_q  <= (i_size > axi_size_t'(2)) ? axi_size_t'(2) : i_size;
			burst_q <= i_burst;
		end
		// fixed bursts keep hitting the same location
		// wrap is stepped like incr
		else if (i_step && (burst_q != BURST_FIXED))
		begin
			addr_q <= next_addr;
		end
	end

	// drop byte offset for wishbone
	assign o_wb_addr = addr_q[AXI_ADDR_W-1:AXI_LSBS];

endmodule

/* tb_axi2wb_write.sv */
// testbench for the AXI4 write to wishbone bridge
// drives AXI bursts, models a stalling wishbone slave that can
// answer one chosen beat with err, checks both buses with assertions
module tb_axi2wb_write;
	timeunit 1ns;
	timeprecision 100ps;
	import axi2wb_pkg::*;

	// six tests need well under 400 cycles
	// worst is 8 beats at half stall plus a 20 cycle held response
	localparam int TIMEOUT_CYCLES = 2000;

	typedef struct packed {
		wb_addr_t addr;
		data_t    data;
		strb_t    sel;
	} beat_t;

	logic      S_AXI_ACLK;
	logic      S_AXI_ARESETN;
	logic      S_AXI_AWVALID;
	logic      S_AXI_AWREADY;
	axi_id_t   S_AXI_AWID;
	axi_addr_t S_AXI_AWADDR;
	beat_len_t S_AXI_AWLEN;
	axi_size_t S_AXI_AWSIZE;
	logic [1:0] S_AXI_AWBURST;
	logic      S_AXI_WVALID;
	logic      S_AXI_WREADY;
	data_t     S_AXI_WDATA;
	strb_t     S_AXI_WSTRB;
	logic      S_AXI_WLAST;
	logic      S_AXI_BVALID;
	logic      S_AXI_BREADY;
	axi_id_t   S_AXI_BID;
	logic [1:0] S_AXI_BRESP;
	logic      o_wb_cyc;
	logic      o_wb_stb;
	wb_addr_t  o_wb_addr;
	data_t     o_wb_data;
	strb_t     o_wb_sel;
	logic      i_wb_stall = 1'b0;
	logic      i_wb_ack = 1'b0;
	logic      i_wb_err = 1'b0;

	// test control
	string     test_name = "reset";
	int        test_num = 0;
	int        tests_failed = 0;
	int        errors = 0;
	int        errors_at_start = 0;
	int        stall_pct = 0;
	// beat of the burst that gets err, -1 for none
	int        err_beat = -1;
	int        cycles = 0;

	// scoreboard state, all sampled at the rising edge
	axi_id_t   aw_id;
	axi_addr_t aw_addr;
	axi_size_t aw_size;
	logic [1:0] aw_burst;
	beat_len_t aw_len;
	logic      burst_open;
	logic      err_flag;
	logic      held;
	beat_t     held_beat;
	logic      b_hold;
	axi_id_t   b_held_id;
	logic [1:0] b_held_resp;
	logic      awready_due;
	logic      resp_pending;
	logic      resp_err;
	int        w_cnt;
	int        strobe_cnt;
	int        ack_cnt;
	beat_t     exp_q[$];
	logic      stb_taken;

	tb_clk_gen u_clk_gen (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN)
	);

	axi2wb_write i_axi2wb_write (.*);

	// a strobe in the err cycle dies with the bus cycle
	assign stb_taken = o_wb_cyc && o_wb_stb && !i_wb_stall && !i_wb_err;

	////////////////////////////////////////////////////////////
	// reporting
	////////////////////////////////////////////////////////////

	task automatic value_error(input string what, input logic [63:0] expv,
		input logic [63:0] actv);
		$display("** Error %s: %s expected %0h, actual %0h", test_name, what, expv, actv);
		errors++;
	endtask

	task automatic plain_error(input string msg);
		$display("%s: %s", test_name, msg);
		errors++;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_num++;
		errors_at_start = errors;
	endtask

	task automatic end_test();
		if (errors == errors_at_start)
			$display("test %0d %s: ok", test_num, test_name);
		else
		begin
			$display("test %0d %s: %0d errors", test_num, test_name,
				errors - errors_at_start);
			tests_failed++;
		end
	endtask

	// word address of beat idx, first beat as given,
	// later ones from the size-aligned start plus idx transfers
	function automatic wb_addr_t beat_addr(input axi_addr_t start, input axi_size_t size,
		input logic [1:0] burst, input int idx);
		axi_addr_t step;
		axi_addr_t addr;
		step = axi_addr_t'(1) << ((size > 3'd2) ? 3'd2 : size);
		if ((burst == BURST_FIXED) || (idx == 0))
			addr = start;
		else
			addr = (start & ~(step - axi_addr_t'(1))) + step * axi_addr_t'(idx);
		return addr[AXI_ADDR_W-1:AXI_LSBS];
	endfunction

	////////////////////////////////////////////////////////////
	// wishbone slave model
	////////////////////////////////////////////////////////////

	// answer last cycle's strobe, pick a new stall
	always @(negedge S_AXI_ACLK)
	begin
		i_wb_ack   = resp_pending && !resp_err;
		i_wb_err   = resp_pending && resp_err;
		i_wb_stall = ($urandom % 100) < stall_pct;
	end

	////////////////////////////////////////////////////////////
	// scoreboard and assertions
	////////////////////////////////////////////////////////////

	always @(posedge S_AXI_ACLK)
	begin : monitor
		beat_t want;
		if (!S_AXI_ARESETN)
		begin
			burst_open   <= 1'b0;
			err_flag     <= 1'b0;
			held         <= 1'b0;
			b_hold       <= 1'b0;
			awready_due  <= 1'b0;
			resp_pending <= 1'b0;
			resp_err     <= 1'b0;
		end
		else
		begin
			assert (!o_wb_stb || o_wb_cyc)
				else plain_error("strobe raised with cyc low");
			// strobe taken, compare against oldest W beat
			if (stb_taken)
			begin
				if (exp_q.size() == 0)
					plain_error("strobe with no W beat behind it");
				else
				begin
					want = exp_q.pop_front();
					assert (o_wb_addr == want.addr)
						else value_error("wb addr", want.addr, o_wb_addr);
					assert (o_wb_data == want.data)
						else value_error("wb data", want.data, o_wb_data);
					assert (o_wb_sel == want.sel)
						else value_error("wb sel", want.sel, o_wb_sel);
				end
				strobe_cnt <= strobe_cnt + 1;
			end
			resp_pending <= stb_taken;
			resp_err     <= stb_taken && (strobe_cnt == err_beat);

			// stalled strobe must not move
			if (held)
			begin
				assert (o_wb_stb) else plain_error("strobe dropped during stall");
				assert ({o_wb_addr, o_wb_data, o_wb_sel} == held_beat)
					else value_error("held beat", held_beat, {o_wb_addr, o_wb_data, o_wb_sel});
			end
			held      <= o_wb_stb && i_wb_stall && !i_wb_err;
			held_beat <= {o_wb_addr, o_wb_data, o_wb_sel};

			// W beat in, expected strobe from the burst rule
			if (S_AXI_WVALID && S_AXI_WREADY)
			begin
				want.addr = beat_addr(aw_addr, aw_size, aw_burst, w_cnt);
				want.data = S_AXI_WDATA;
				want.sel  = S_AXI_WSTRB;
				exp_q.push_back(want);
				w_cnt <= w_cnt + 1;
			end

			if (S_AXI_AWVALID && S_AXI_AWREADY)
			begin
				aw_id      <= S_AXI_AWID;
				aw_addr    <= S_AXI_AWADDR;
				aw_size    <= S_AXI_AWSIZE;
				aw_burst   <= S_AXI_AWBURST;
				aw_len     <= S_AXI_AWLEN;
				burst_open <= 1'b1;
				err_flag   <= 1'b0;
				w_cnt      <= 0;
				strobe_cnt <= 0;
				ack_cnt    <= 0;
			end

			if (burst_open)
			begin
				assert (!S_AXI_AWREADY) else plain_error("AWREADY high during a burst");
				// no more W taken once the burst length is reached
				if (w_cnt == aw_len + 1)
				begin
					assert (!S_AXI_WREADY) else plain_error("WREADY high after the last W beat");
				end
				if (err_flag)
				begin
					assert (!o_wb_cyc) else plain_error("cyc still high after a bus error");
				end
				else if (ack_cnt < aw_len + 1)
				begin
					assert (o_wb_cyc) else plain_error("cyc dropped before the last ack");
				end
				if (i_wb_ack)
					ack_cnt <= ack_cnt + 1;
				if (i_wb_err)
					err_flag <= 1'b1;
			end

			// response channel
			assert (!S_AXI_BVALID || burst_open)
				else plain_error("BVALID with no burst open");
			if (b_hold)
			begin
				assert (S_AXI_BVALID && (S_AXI_BID == b_held_id) && (S_AXI_BRESP == b_held_resp))
					else plain_error("B channel changed before BREADY");
			end
			b_hold      <= S_AXI_BVALID && !S_AXI_BREADY;
			b_held_id   <= S_AXI_BID;
			b_held_resp <= S_AXI_BRESP;

			if (S_AXI_BVALID && S_AXI_BREADY && burst_open)
			begin
				assert (S_AXI_BID == aw_id) else value_error("BID", aw_id, S_AXI_BID);
				assert (S_AXI_BRESP == ((err_beat >= 0) ? RESP_SLVERR : RESP_OKAY))
					else value_error("BRESP", (err_beat >= 0) ? RESP_SLVERR : RESP_OKAY,
						S_AXI_BRESP);
				assert (w_cnt == aw_len + 1) else value_error("W beats taken", aw_len + 1, w_cnt);
				assert (strobe_cnt == ((err_beat >= 0) ? err_beat + 1 : aw_len + 1))
					else value_error("strobes issued",
						(err_beat >= 0) ? err_beat + 1 : aw_len + 1, strobe_cnt);
				assert (!o_wb_cyc) else plain_error("cyc high at the B handshake");
				// beats dropped after an error never reach the bus
				exp_q.delete();
				burst_open <= 1'b0;
			end

			// AW opens again right after B
			if (awready_due)
			begin
				assert (S_AXI_AWREADY) else plain_error("AWREADY not back after B");
			end
			awready_due <= S_AXI_BVALID && S_AXI_BREADY;
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	// one burst, AW then W then B, entered and left on a falling edge
	task automatic run_burst(input axi_id_t id, input axi_addr_t addr, input int n,
		input logic [1:0] burst, input int gap_pct, input int hold);
		int i;
		S_AXI_BREADY  = (hold == 0);
		S_AXI_AWVALID = 1'b1;
		S_AXI_AWID    = id;
		S_AXI_AWADDR  = addr;
		S_AXI_AWLEN   = beat_len_t'(n - 1);
		S_AXI_AWSIZE  = 3'd2;
		S_AXI_AWBURST = burst;
		do
			@(posedge S_AXI_ACLK);
		while (!S_AXI_AWREADY);
		@(negedge S_AXI_ACLK);
		S_AXI_AWVALID = 1'b0;

		for (i = 0; i < n; i++)
		begin
			// random idle cycles on W
			while (($urandom % 100) < gap_pct)
			begin
				S_AXI_WVALID = 1'b0;
				@(negedge S_AXI_ACLK);
			end
			S_AXI_WVALID = 1'b1;
			S_AXI_WDATA  = data_t'($urandom);
			S_AXI_WSTRB  = strb_t'($urandom);
			S_AXI_WLAST  = (i == n - 1);
			do
				@(posedge S_AXI_ACLK);
			while (!S_AXI_WREADY);
			@(negedge S_AXI_ACLK);
		end
		S_AXI_WVALID = 1'b0;
		S_AXI_WLAST  = 1'b0;

		// held response, BREADY late
		if (hold > 0)
		begin
			do
				@(posedge S_AXI_ACLK);
			while (!S_AXI_BVALID);
			repeat (hold) @(negedge S_AXI_ACLK);
			S_AXI_BREADY = 1'b1;
		end
		do
			@(posedge S_AXI_ACLK);
		while (!(S_AXI_BVALID && S_AXI_BREADY));
		@(negedge S_AXI_ACLK);
	endtask

	initial
	begin
		void'($urandom(30));
		S_AXI_AWVALID = 1'b0;
		S_AXI_AWID    = '0;
		S_AXI_AWADDR  = '0;
		S_AXI_AWLEN   = '0;
		S_AXI_AWSIZE  = '0;
		S_AXI_AWBURST = '0;
		S_AXI_WVALID  = 1'b0;
		S_AXI_WDATA   = '0;
		S_AXI_WSTRB   = '0;
		S_AXI_WLAST   = 1'b0;
		S_AXI_BREADY  = 1'b1;

		// idle outputs, AWREADY one cycle after release
		@(posedge S_AXI_ARESETN);
		@(posedge S_AXI_ACLK);
		assert (!S_AXI_WREADY && !o_wb_cyc && !o_wb_stb && !S_AXI_BVALID)
			else plain_error("outputs not idle after reset");
		@(posedge S_AXI_ACLK);
		assert (S_AXI_AWREADY) else plain_error("AWREADY not high after reset");
		@(negedge S_AXI_ACLK);

		start_test("single beat");
		run_burst(6'h15, 28'h0001234, 1, BURST_INCR, 0, 0);
		end_test();

		start_test("incr burst");
		run_burst(6'h2a, 28'h0100008, 4, BURST_INCR, 0, 0);
		end_test();

		start_test("fixed burst");
		run_burst(6'h07, 28'h0200010, 3, BURST_FIXED, 0, 0);
		end_test();

		// unaligned start, first beat aligns the rest
		start_test("stall back-pressure");
		stall_pct = 50;
		run_burst(6'h31, 28'h0300006, 8, BURST_INCR, 40, 0);
		end_test();

		start_test("error mid-burst");
		stall_pct = 20;
		err_beat  = 2;
		run_burst(6'h0c, 28'h0400000, 5, BURST_INCR, 0, 0);
		err_beat = -1;
		run_burst(6'h0d, 28'h0400100, 2, BURST_INCR, 0, 0);
		end_test();

		start_test("held response");
		stall_pct = 0;
		run_burst(6'h3f, 28'h0500020, 2, BURST_INCR, 0, 20);
		end_test();

		$display("%0d tests run, %0d failed, %0d errors", test_num, tests_failed, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// watchdog
	always @(posedge S_AXI_ACLK)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("run stopped, no progress after %0d cycles in test %s", cycles, test_name);
			$display("Simulation failed");
			$finish;
		end
	end

endmodule

/* tb_clk_gen.sv */
// testbench clock and reset source
// 8 ns clock, active low reset held for 10 cycles
module tb_clk_gen (
	output logic S_AXI_ACLK,
	output logic S_AXI_ARESETN
);
	timeunit 1ns;
	timeprecision 100ps;

	// half of the 8 ns period
	localparam time HALF_PERIOD = 4ns;

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever
			#HALF_PERIOD S_AXI_ACLK = ~S_AXI_ACLK;
	end

	// release on a falling edge, like every other DUT input
	initial
	begin
		S_AXI_ARESETN = 1'b0;
		repeat (10) @(posedge S_AXI_ACLK);
		@(negedge S_AXI_ACLK);
		S_AXI_ARESETN = 1'b1;
	end

endmodule

/* wb_beat_if.sv */
// one write beat handed from the burst FSM to the wishbone issue stage
// valid/ready handshake, beat moves on an edge with both high
interface wb_beat_if;
	import axi2wb_pkg::*;

	// handshake
	logic     valid;
	logic     ready;

	// beat payload
	wb_addr_t addr;
	data_t    data;
	strb_t    sel;

	// burst FSM side
	modport ctrl (
		output valid,
		output addr,
		output data,
		output sel,
		input  ready
	);

	// output register side
	modport issue (
		input  valid,
		input  addr,
		input  data,
		input  sel,
		output ready
	);

endinterface

/* wb_write_issue.sv */
// wishbone write request stage
// registers strobe, address, data and select for one beat,
// holds them through stall, flags each strobe the slave takes
module wb_write_issue (
	input  logic                 S_AXI_ACLK,
	input  logic                 S_AXI_ARESETN,
	input  logic                 i_abort,
	input  logic                 i_wb_stall,
	wb_beat_if.issue             beat,
	output logic                 o_wb_stb,
	output axi2wb_pkg::wb_addr_t o_wb_addr,
	output axi2wb_pkg::data_t    o_wb_data,
	output axi2wb_pkg::strb_t    o_wb_sel,
	output logic                 o_issued
);

	////////////////////////////////////////////////////////////
	// handshake
	////////////////////////////////////////////////////////////

	// register is free when empty or its strobe goes out now
	assign beat.ready = !o_wb_stb || !i_wb_stall;

	// slave accepted the current strobe
	assign o_issued = o_wb_stb && !i_wb_stall;

	////////////////////////////////////////////////////////////
	// output registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_wb_stb <= 1'b0;
		// bus error ends the cycle, nothing more goes out
		else if (i_abort)
			o_wb_stb <= 1'b0;
		else if (beat.ready)
			o_wb_stb <= beat.valid;
	end

	// payload only moves with a new beat
	// so it stays put while stalled
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (beat.valid && beat.ready)
		begin
			o_wb_addr <= beat.addr;
			o_wb_data <= beat.data;
			o_wb_sel  <= beat.sel;
		end
	end

endmodule

/* write_ctrl.sv */
// AXI write burst controller
// accepts one AW at a time, passes its W beats to the wishbone
// issue stage, discards the rest after a bus error, then
// returns a single B response with the captured ID
module write_ctrl (
	input  logic                   S_AXI_ACLK,
	input  logic                   S_AXI_ARESETN,
	input  logic                   i_awvalid,
	input  axi2wb_pkg::axi_id_t    i_awid,
	input  axi2wb_pkg::beat_len_t  i_awlen,
	input  logic                   i_wvalid,
	input  axi2wb_pkg::data_t      i_wdata,
	input  axi2wb_pkg::strb_t      i_wstrb,
	input  logic                   i_bready,
	input  axi2wb_pkg::wb_addr_t   i_cur_addr,
	input  logic                   i_idle,
	input  logic                   i_err,
	output logic                   o_awready,
	output logic                   o_wready,
	output logic                   o_wb_cyc,
	output logic                   o_bvalid,
	output axi2wb_pkg::axi_id_t    o_bid,
	output logic [1:0]             o_bresp,
	output logic                   o_load,
	output logic                   o_step,
	output logic                   o_start,
	wb_beat_if.ctrl                beat
);
	import axi2wb_pkg::*;

	wr_state_t state_q;
	wr_state_t state_nxt;
	logic      cyc_nxt;

	// beats still to come, minus one
	beat_len_t beats_left;
	// every W beat of the burst taken
	logic      w_done;

	logic      aw_take;
	logic      w_take;
	logic      burst_done;

	////////////////////////////////////////////////////////////
	// channel handshakes
	////////////////////////////////////////////////////////////

	assign aw_take = o_awready && i_awvalid;
	assign o_load  = aw_take;
	assign o_start = aw_take;

	// W goes straight onto the beat interface until the last beat is in
	assign beat.valid = (state_q == ST_BURST) && !w_done && i_wvalid && !i_err;
	assign beat.addr  = i_cur_addr;
	assign beat.data  = i_wdata;
	assign beat.sel   = i_wstrb;

	// drain swallows whatever is left of a failed burst
	assign o_wready = ((state_q == ST_BURST) && !w_done && beat.ready && !i_err)
		|| (state_q == ST_DRAIN);
	assign w_take = i_wvalid && o_wready;
	assign o_step = (state_q == ST_BURST) && w_take;

	// last strobe out and acknowledged
	assign burst_done = w_done && beat.ready && i_idle;

	assign o_bvalid = (state_q == ST_RESP);

	////////////////////////////////////////////////////////////
	// burst FSM
	////////////////////////////////////////////////////////////

	always_comb
	begin
		state_nxt = state_q;
		cyc_nxt   = o_wb_cyc;
		case (state_q)
			ST_IDLE:
			begin
				if (aw_take)
				begin
					state_nxt = ST_BURST;
					cyc_nxt   = 1'b1;
				end
			end
			ST_BURST:
			begin
				// bus error, release the bus at once
				if (i_err)
				begin
					cyc_nxt   = 1'b0;
					state_nxt = w_done ? ST_RESP : ST_DRAIN;
				end
				else if (burst_done)
				begin
					cyc_nxt   = 1'b0;
					state_nxt = ST_RESP;
				end
			end
			ST_DRAIN:
			begin
				if (w_take && (beats_left == '0))
					state_nxt = ST_RESP;
			end
			ST_RESP:
			begin
				if (i_bready)
					state_nxt = ST_IDLE;
			end
			default:
				state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			state_q   <= ST_IDLE;
			o_awready <= 1'b0;
			o_wb_cyc  <= 1'b0;
		end
		else
		begin
			state_q   <= state_nxt;
			// ready for AW whenever the FSM lands in idle
			o_awready <= (state_nxt == ST_IDLE);
			o_wb_cyc  <= cyc_nxt;
		end
	end

	// W beat countdown from AWLEN
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			beats_left <= '0;
			w_done     <= 1'b1;
		end
		else if (aw_take)
		begin
			beats_left <= i_awlen;
			w_done     <= 1'b0;
		end
		else if (w_take)
		begin
			if (beats_left == '0)
				w_done <= 1'b1;
			else
				beats_left <= beats_left - beat_len_t'(1);
		end
	end

	// B payload, ID at AW time, status on entry to response
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (aw_take)
			o_bid <= i_awid;
		if ((state_q != ST_RESP) && (state_nxt == ST_RESP))
			o_bresp <= i_err ? RESP_SLVERR : RESP_OKAY;
	end

endmodule
